// ==== build.f ====
+incdir+.
pic_pkg.sv
pic_ctrl_regs.sv
pic_request_reg.sv
pic_service_ctrl.sv
pic_core.sv
pic.sv
tb_pic.sv

// ==== Bender.yml ====
package:
  name: pic_cascade

sources:
  - pic_pkg.sv
  - pic_ctrl_regs.sv
  - pic_request_reg.sv
  - pic_service_ctrl.sv
  - pic_core.sv
  - pic.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pic.sv

// ==== tb_pic_tasks.svh ====
`ifndef TB_PIC_TASKS_SVH
`define TB_PIC_TASKS_SVH

// --------------------------------------------------
// error handling and compares
// --------------------------------------------------
task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
        stop_on_error($sformatf("Mismatch at %0t ns: %s is 0x%02h, expected 0x%02h",
                                $time, name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
        stop_on_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
endtask

// --------------------------------------------------
// command bytes
// --------------------------------------------------
function automatic logic [7:0] icw1_byte(input logic ltim);
    pic_cmd_u cmd;
    cmd.raw       = 8'h00;
    cmd.icw1.init = 1'b1;
    cmd.icw1.ltim = ltim;
    cmd.icw1.ic4  = 1'b1;                               // icw4 follows
    return cmd.raw;
endfunction

function automatic logic [7:0] ocw3_byte(input logic read_isr);
    pic_cmd_u cmd;
    cmd.raw      = 8'h00;
    cmd.ocw3.sel = PIC_SEL_OCW3;
    cmd.ocw3.rr  = 1'b1;
    cmd.ocw3.ris = read_isr;
    return cmd.raw;
endfunction

function automatic logic [7:0] spec_eoi_byte(input logic [2:0] line);
    pic_cmd_u cmd;
    cmd.raw       = PIC_SPEC_EOI;
    cmd.ocw2.line = line;
    return cmd.raw;
endfunction

function automatic logic [2:0] pick_master_line();
    logic [2:0] line;
    line = 3'($urandom % 7);
    if (line >= PIC_CASCADE_LINE)
        line = line + 3'd1;                             // skip the cascade input
    return line;
endfunction

// --------------------------------------------------
// bus and acknowledge
// --------------------------------------------------
task automatic write_reg(input logic to_master, input logic addr, input logic [7:0] data);
    io_write     = 1'b1;
    io_address   = addr;
    io_writedata = data;
    io_master_cs = to_master;
    io_slave_cs  = !to_master;
    @(negedge clk);
    io_write     = 1'b0;
    io_master_cs = 1'b0;
    io_slave_cs  = 1'b0;
endtask

task automatic read_check(input logic from_master, input logic addr, input string name,
                          input logic [7:0] exp);
    io_read      = 1'b1;
    io_address   = addr;
    io_master_cs = from_master;
    io_slave_cs  = !from_master;
    @(negedge clk);
    io_read      = 1'b0;
    io_master_cs = 1'b0;
    io_slave_cs  = 1'b0;
    check_byte(name, io_readdata, exp);                 // registered on the edge just passed
endtask

task automatic init_chip(input logic to_master, input logic ltim, input logic [7:0] base,
                         input logic [7:0] icw3);
    write_reg(to_master, 1'b0, icw1_byte(ltim));
    write_reg(to_master, 1'b1, base);
    write_reg(to_master, 1'b1, icw3);
    write_reg(to_master, 1'b1, 8'h01);                  // icw4
endtask

task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (interrupt_do !== 1'b1 && cycles < 6) begin
        @(negedge clk);
        cycles = cycles + 1;
    end
    if (interrupt_do !== 1'b1)
        stop_on_error("interrupt_do did not rise within 6 cycles of the request");
endtask

task automatic pulse_done();
    interrupt_done = 1'b1;
    @(negedge clk);
    interrupt_done = 1'b0;
    check_flag("interrupt_do", interrupt_do, 1'b0);     // drops on the ack edge
endtask

task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_flag("interrupt_do", interrupt_do, 1'b0);
    end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic reset_and_init();
    read_check(1'b1, 1'b1, "master IMR", 8'hFF);
    read_check(1'b0, 1'b1, "slave IMR", 8'hFF);
    init_chip(1'b1, 1'b0, 8'h08, 8'h04);
    init_chip(1'b0, 1'b0, 8'h70, 8'h02);
    read_check(1'b1, 1'b1, "master IMR", 8'h00);
    read_check(1'b0, 1'b1, "slave IMR", 8'h00);
    check_flag("interrupt_do", interrupt_do, 1'b0);
endtask

task automatic edge_request();
    logic [2:0] line;
    line = pick_master_line();
    interrupt_input[line] = 1'b1;
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h08 + 8'(line));
    pulse_done();
    interrupt_input[line] = 1'b0;
    write_reg(1'b1, 1'b0, ocw3_byte(1'b1));             // read isr from now on
    read_check(1'b1, 1'b0, "master ISR", 8'h01 << line);
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    read_check(1'b1, 1'b0, "master ISR", 8'h00);
    expect_quiet(3);
endtask

task automatic priority_and_mask();
    interrupt_input[3] = 1'b1;
    interrupt_input[6] = 1'b1;
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h0B);
    pulse_done();
    read_check(1'b1, 1'b0, "master ISR", 8'h08);
    interrupt_input[6] = 1'b0;                          // fresh edge on 6 while 3 in service
    repeat (2) @(negedge clk);
    interrupt_input[6] = 1'b1;
    expect_quiet(5);
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h0E);
    pulse_done();
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    interrupt_input[3] = 1'b0;
    interrupt_input[6] = 1'b0;
    repeat (2) @(negedge clk);

    write_reg(1'b1, 1'b1, 8'h08);                       // mask line 3
    interrupt_input[3] = 1'b1;
    interrupt_input[6] = 1'b1;
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h0E);
    pulse_done();
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    read_check(1'b1, 1'b1, "master IMR", 8'h08);
    interrupt_input[3] = 1'b0;
    interrupt_input[6] = 1'b0;
    repeat (2) @(negedge clk);
    write_reg(1'b1, 1'b1, 8'h00);
    expect_quiet(3);
endtask

task automatic cascade_request();
    interrupt_input[9] = 1'b1;                          // slave line 1
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h71);
    pulse_done();
    interrupt_input[9] = 1'b0;
    write_reg(1'b0, 1'b0, ocw3_byte(1'b1));
    read_check(1'b1, 1'b0, "master ISR", 8'h04);
    read_check(1'b0, 1'b0, "slave ISR", 8'h02);
    write_reg(1'b1, 1'b0, spec_eoi_byte(3'd2));
    write_reg(1'b0, 1'b0, spec_eoi_byte(3'd1));
    read_check(1'b1, 1'b0, "master ISR", 8'h00);
    read_check(1'b0, 1'b0, "slave ISR", 8'h00);
    expect_quiet(3);
endtask

task automatic level_mode();
    init_chip(1'b1, 1'b1, 8'h08, 8'h04);
    write_reg(1'b1, 1'b0, ocw3_byte(1'b0));             // read irr
    interrupt_input[5] = 1'b1;
    wait_irq();
    check_byte("interrupt_vector", interrupt_vector, 8'h0D);
    repeat (3) @(negedge clk);
    read_check(1'b1, 1'b0, "master IRR", 8'h20);
    interrupt_input[5] = 1'b0;
    repeat (2) @(negedge clk);
    read_check(1'b1, 1'b0, "master IRR", 8'h00);
    check_flag("interrupt_do", interrupt_do, 1'b1);     // still pending
    pulse_done();
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    expect_quiet(4);

    interrupt_input[5] = 1'b1;                          // held through ack and eoi
    wait_irq();
    pulse_done();
    read_check(1'b1, 1'b0, "master IRR", 8'h20);
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    wait_irq();                                         // held level asks again
    check_byte("interrupt_vector", interrupt_vector, 8'h0D);
    interrupt_input[5] = 1'b0;
    pulse_done();
    write_reg(1'b1, 1'b0, PIC_NONSPEC_EOI);
    expect_quiet(4);
endtask

`endif

// ==== tb_pic.sv ====
`timescale 1ns/10ps

module tb_pic
    import pic_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 300;

    logic        clk;
    logic        rst_n;
    logic        io_address;
    logic        io_read;
    logic [7:0]  io_readdata;
    logic        io_write;
    logic [7:0]  io_writedata;
    logic        io_master_cs;
    logic        io_slave_cs;
    logic [15:0] interrupt_input;
    logic        interrupt_do;
    logic [7:0]  interrupt_vector;
    logic        interrupt_done;
    int unsigned seed_value;

    pic u_pic (
        .clk              (clk),
        .rst_n            (rst_n),
        .io_address       (io_address),
        .io_read          (io_read),
        .io_readdata      (io_readdata),
        .io_write         (io_write),
        .io_writedata     (io_writedata),
        .io_master_cs     (io_master_cs),
        .io_slave_cs      (io_slave_cs),
        .interrupt_input  (interrupt_input),
        .interrupt_do     (interrupt_do),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done)
    );

    `include "tb_pic_tasks.svh"

    // --------------------------------------------------
    // clock and watchdog
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);     // generous bound per test
        stop_on_error("Watchdog expired before the tests finished");
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        seed_value      = $urandom(31);
        rst_n           = 1'b0;
        io_address      = 1'b0;
        io_read         = 1'b0;
        io_write        = 1'b0;
        io_writedata    = 8'h00;
        io_master_cs    = 1'b0;
        io_slave_cs     = 1'b0;
        interrupt_input = 16'h0000;
        interrupt_done  = 1'b0;

        repeat (3) @(negedge clk);                     // three reset edges
        rst_n = 1'b1;
        @(negedge clk);

        reset_and_init();
        edge_request();
        priority_and_mask();
        cascade_request();
        level_mode();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== pic.sv ====
`timescale 1ns/10ps

module pic
    import pic_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        io_address,
    input  logic        io_read,
    output logic [7:0]  io_readdata,
    input  logic        io_write,
    input  logic [7:0]  io_writedata,
    input  logic        io_master_cs,
    input  logic        io_slave_cs,
    input  logic [15:0] interrupt_input,
    output logic        interrupt_do,
    output logic [7:0]  interrupt_vector,
    input  logic        interrupt_done
);

    logic                    mas_req;
    logic [PIC_LINE_W-1:0]   mas_req_line;
    logic                    mas_pending;
    logic [PIC_OFFSET_W-1:0] mas_offset;
    logic                    mas_init;
    logic [7:0]              mas_readdata;
    logic [PIC_LINES-1:0]    mas_irq_in;
    logic [PIC_LINE_W-1:0]   mas_ack_line;

    logic [PIC_LINE_W-1:0]   sla_req_line;
    logic                    sla_pending;
    logic [PIC_OFFSET_W-1:0] sla_offset;
    logic                    sla_init;
    logic [7:0]              sla_readdata;

    logic                    slave_active;             // current vector from slave
    logic                    mas_active;
    logic                    mas_sel_slave;

    // slave request replaces master input 2
    assign mas_irq_in = {interrupt_input[7:3], sla_pending, interrupt_input[1:0]};

    assign mas_ack_line = slave_active ? PIC_CASCADE_LINE
                                       : interrupt_vector[PIC_LINE_W-1:0];

    pic_core #(
        .OFFSET_RESET (PIC_MAS_OFFSET_RESET)
    ) u_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .write       (io_write && io_master_cs),
        .address     (io_address),
        .writedata   (io_writedata),
        .irq_in      (mas_irq_in),
        .ack         (interrupt_done),
        .ack_line    (mas_ack_line),
        .req         (mas_req),
        .req_line    (mas_req_line),
        .req_pending (mas_pending),
        .offset      (mas_offset),
        .init_start  (mas_init),
        .readdata    (mas_readdata)
    );

    pic_core #(
        .OFFSET_RESET (PIC_SLA_OFFSET_RESET)
    ) u_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .write       (io_write && io_slave_cs),
        .address     (io_address),
        .writedata   (io_writedata),
        .irq_in      (interrupt_input[15:8]),
        .ack         (interrupt_done && slave_active),
        .ack_line    (interrupt_vector[PIC_LINE_W-1:0]),
        .req         (),
        .req_line    (sla_req_line),
        .req_pending (sla_pending),
        .offset      (sla_offset),
        .init_start  (sla_init),
        .readdata    (sla_readdata)
    );

    // --------------------------------------------------
    // cpu side
    // --------------------------------------------------
    assign mas_active    = mas_req || mas_pending;
    assign mas_sel_slave = mas_req_line == PIC_CASCADE_LINE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slave_active     <= 1'b0;
            interrupt_do     <= 1'b0;
            interrupt_vector <= '0;
        end else if (mas_init) begin
            slave_active     <= 1'b0;
            interrupt_do     <= 1'b0;
            interrupt_vector <= '0;
        end else begin
            if (interrupt_done || sla_init)
                slave_active <= 1'b0;
            else if (mas_active)
                slave_active <= mas_sel_slave;

            if (interrupt_done)
                interrupt_do <= 1'b0;
            else if (mas_req)
                interrupt_do <= 1'b1;

            if (mas_active)
                interrupt_vector <= mas_sel_slave ? {sla_offset, sla_req_line}
                                                  : {mas_offset, mas_req_line};
        end
    end

    // read data held until the next read
    always_ff @(posedge clk) begin
        if (io_read)
            io_readdata <= io_master_cs ? mas_readdata : sla_readdata;
    end

endmodule

// ==== pic_core.sv ====
`timescale 1ns/10ps

module pic_core
    import pic_pkg::*;
#(
    parameter logic [PIC_OFFSET_W-1:0] OFFSET_RESET = PIC_MAS_OFFSET_RESET
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    write,
    input  logic                    address,
    input  logic [7:0]              writedata,
    input  logic [PIC_LINES-1:0]    irq_in,
    input  logic                    ack,
    input  logic [PIC_LINE_W-1:0]   ack_line,
    output logic                    req,
    output logic [PIC_LINE_W-1:0]   req_line,
    output logic                    req_pending,
    output logic [PIC_OFFSET_W-1:0] offset,
    output logic                    init_start,
    output logic [7:0]              readdata
);

    pic_cfg_t              cfg;
    logic                  eoi_clear_top;
    logic                  eoi_clear_line;
    logic [PIC_LINE_W-1:0] eoi_line;
    logic [PIC_LINES-1:0]  irr;
    logic [PIC_LINES-1:0]  isr;

    pic_ctrl_regs #(
        .OFFSET_RESET (OFFSET_RESET)
    ) u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .write          (write),
        .address        (address),
        .writedata      (writedata),
        .cfg            (cfg),
        .init_start     (init_start),
        .eoi_clear_top  (eoi_clear_top),
        .eoi_clear_line (eoi_clear_line),
        .eoi_line       (eoi_line)
    );

    pic_request_reg u_req (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_in     (irq_in),
        .cfg        (cfg),
        .init_start (init_start),
        .ack        (ack),
        .ack_line   (ack_line),
        .irr        (irr)
    );

    pic_service_ctrl u_svc (
        .clk            (clk),
        .rst_n          (rst_n),
        .irr            (irr),
        .cfg            (cfg),
        .init_start     (init_start),
        .ack            (ack),
        .ack_line       (ack_line),
        .eoi_clear_top  (eoi_clear_top),
        .eoi_clear_line (eoi_clear_line),
        .eoi_line       (eoi_line),
        .isr            (isr),
        .req            (req),
        .req_line       (req_line)
    );

    // request seen, waiting for acknowledge
    always_ff @(posedge clk) begin
        if (!rst_n)
            req_pending <= 1'b0;
        else if (init_start || ack)
            req_pending <= 1'b0;
        else if (req)
            req_pending <= 1'b1;
    end

    assign offset   = cfg.offset;
    assign readdata = address      ? cfg.mask :         // imr
                      cfg.read_isr ? isr : irr;

endmodule

// ==== pic_service_ctrl.sv ====
`timescale 1ns/10ps

module pic_service_ctrl
    import pic_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [PIC_LINES-1:0]  irr,
    input  pic_cfg_t              cfg,
    input  logic                  init_start,
    input  logic                  ack,
    input  logic [PIC_LINE_W-1:0] ack_line,
    input  logic                  eoi_clear_top,
    input  logic                  eoi_clear_line,
    input  logic [PIC_LINE_W-1:0] eoi_line,
    output logic [PIC_LINES-1:0]  isr,
    output logic                  req,
    output logic [PIC_LINE_W-1:0] req_line
);

    logic [PIC_LINES-1:0]  cand;
    logic [PIC_LINE_W:0]   cand_lvl;                    // PIC_LINES when empty
    logic [PIC_LINE_W:0]   isr_lvl;
    logic [PIC_LINES-1:0]  clr_bits;
    logic [PIC_LINES-1:0]  set_bits;

    // lowest set line wins, extra bit flags none set
    function automatic logic [PIC_LINE_W:0] first_set(input logic [PIC_LINES-1:0] bits);
        logic [PIC_LINE_W:0] idx;
        idx = (PIC_LINE_W+1)'(PIC_LINES);
        for (int i = PIC_LINES - 1; i >= 0; i--) begin
            if (bits[i])
                idx = (PIC_LINE_W+1)'(i);
        end
        return idx;
    endfunction

    // --------------------------------------------------
    // fixed priority resolver
    // --------------------------------------------------
    assign cand     = irr & ~cfg.mask & ~isr;
    assign cand_lvl = first_set(cand);
    assign isr_lvl  = first_set(isr);

    // in-service lines block equal and lower priority
    assign req      = (cand != '0) && (cand_lvl < isr_lvl);
    assign req_line = req ? cand_lvl[PIC_LINE_W-1:0] : 3'd7;

    // --------------------------------------------------
    // in-service register
    // --------------------------------------------------
    always_comb begin
        clr_bits = '0;
        if (eoi_clear_line)
            clr_bits = PIC_LINES'(1) << eoi_line;
        else if (eoi_clear_top && !isr_lvl[PIC_LINE_W])
            clr_bits = PIC_LINES'(1) << isr_lvl[PIC_LINE_W-1:0];  // highest in service
    end

    assign set_bits = ack ? (PIC_LINES'(1) << ack_line) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n)
            isr <= '0;
        else if (init_start)
            isr <= '0;
        else
            isr <= (isr & ~clr_bits) | set_bits;
    end

endmodule

// ==== pic_request_reg.sv ====
`timescale 1ns/10ps

module pic_request_reg
    import pic_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [PIC_LINES-1:0]  irq_in,
    input  pic_cfg_t              cfg,
    input  logic                  init_start,
    input  logic                  ack,
    input  logic [PIC_LINE_W-1:0] ack_line,
    output logic [PIC_LINES-1:0]  irr
);

    logic [PIC_LINES-1:0] irq_last;                     // previous sample
    logic [PIC_LINES-1:0] rise;
    logic [PIC_LINES-1:0] ack_bits;
    logic [PIC_LINES-1:0] new_req;

    always_ff @(posedge clk) begin
        if (!rst_n)
            irq_last <= '0;
        else
            irq_last <= irq_in;
    end

    assign rise     = irq_in & ~irq_last;
    assign ack_bits = ack ? (PIC_LINES'(1) << ack_line) : '0;
    assign new_req  = cfg.ltim ? irq_in : rise;         // level or edge

    // a request survives only while its input stays high
    always_ff @(posedge clk) begin
        if (!rst_n)
            irr <= '0;
        else if (init_start)
            irr <= '0;
        else
            irr <= (irr & irq_in & ~ack_bits) | new_req;
    end

endmodule

// ==== pic_ctrl_regs.sv ====
`timescale 1ns/10ps

module pic_ctrl_regs
    import pic_pkg::*;
#(
    parameter logic [PIC_OFFSET_W-1:0] OFFSET_RESET = PIC_MAS_OFFSET_RESET
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  write,
    input  logic                  address,
    input  logic [7:0]            writedata,
    output pic_cfg_t              cfg,
    output logic                  init_start,
    output logic                  eoi_clear_top,
    output logic                  eoi_clear_line,
    output logic [PIC_LINE_W-1:0] eoi_line
);

    pic_cmd_u   cmd;
    logic       cmd_write;
    logic       data_write;
    logic       icw1;
    logic       icw2;
    logic       icw3;
    logic       icw4;
    logic       ocw1;
    logic       ocw2;
    logic       ocw3;
    logic       in_init;
    logic       need_icw4;
    logic [2:0] byte_expected;                          // next icw number

    assign cmd        = writedata;
    assign cmd_write  = write && !address;
    assign data_write = write && address;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------
    assign icw1 = cmd_write && cmd.icw1.init;
    assign ocw2 = cmd_write && cmd.ocw3.sel == PIC_SEL_OCW2;
    assign ocw3 = cmd_write && cmd.ocw3.sel == PIC_SEL_OCW3;

    assign icw2 = data_write && in_init && byte_expected == 3'd2;
    assign icw3 = data_write && in_init && byte_expected == 3'd3;  // contents ignored
    assign icw4 = data_write && in_init && byte_expected == 3'd4;  // contents ignored
    assign ocw1 = data_write && !in_init;

    // init sequence
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_init       <= 1'b0;
            need_icw4     <= 1'b0;
            byte_expected <= 3'd0;
        end else if (icw1) begin
            in_init       <= 1'b1;
            need_icw4     <= cmd.icw1.ic4;
            byte_expected <= 3'd2;
        end else begin
            if (icw2)
                byte_expected <= 3'd3;
            if (icw3 && need_icw4)
                byte_expected <= 3'd4;
            if ((icw3 && !need_icw4) || icw4)
                in_init <= 1'b0;                        // sequence done
        end
    end

    // --------------------------------------------------
    // mask, mode and read select
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.mask     <= PIC_IMR_RESET;
            cfg.ltim     <= 1'b0;
            cfg.offset   <= OFFSET_RESET;
            cfg.read_isr <= 1'b0;
        end else begin
            if (icw1) begin
                cfg.mask     <= '0;                     // icw1 unmasks everything
                cfg.ltim     <= cmd.icw1.ltim;
                cfg.read_isr <= 1'b0;
            end else begin
                if (ocw1)
                    cfg.mask <= writedata;
                if (ocw3 && cmd.ocw3.rr)
                    cfg.read_isr <= cmd.ocw3.ris;
            end
            if (icw2)
                cfg.offset <= cmd.raw[7:PIC_LINE_W];    // vector base
        end
    end

    // eoi commands, other ocw2 codes fall through
    assign init_start     = icw1;
    assign eoi_clear_top  = ocw2 && (cmd.raw == PIC_NONSPEC_EOI ||
                                     cmd.raw == PIC_ROT_NONSPEC_EOI);
    assign eoi_clear_line = ocw2 && ({cmd.ocw2.code, 3'b000} == PIC_SPEC_EOI ||
                                     {cmd.ocw2.code, 3'b000} == PIC_ROT_SPEC_EOI);
    assign eoi_line       = cmd.ocw2.line;

endmodule

// ==== pic_pkg.sv ====
package pic_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int PIC_LINES    = 8;            // request lines per core
    localparam int PIC_LINE_W   = 3;            // line index width
    localparam int PIC_OFFSET_W = 5;            // vector offset from icw2

    localparam logic [PIC_LINE_W-1:0] PIC_CASCADE_LINE = 3'd2; // master line fed by slave

    // --------------------------------------------------
    // reset values
    // --------------------------------------------------
    localparam logic [PIC_LINES-1:0]    PIC_IMR_RESET        = 8'hFF; // all masked
    localparam logic [PIC_OFFSET_W-1:0] PIC_MAS_OFFSET_RESET = 5'h01;
    localparam logic [PIC_OFFSET_W-1:0] PIC_SLA_OFFSET_RESET = 5'h0E;

    // --------------------------------------------------
    // command codes
    // --------------------------------------------------
    localparam logic [1:0] PIC_SEL_OCW2 = 2'b00;            // select field at bits 4:3
    localparam logic [1:0] PIC_SEL_OCW3 = 2'b01;

    localparam logic [7:0] PIC_NONSPEC_EOI     = 8'h20;
    localparam logic [7:0] PIC_SPEC_EOI        = 8'h60;     // line in low bits
    localparam logic [7:0] PIC_ROT_NONSPEC_EOI = 8'hA0;     // rotation gone, still an eoi
    localparam logic [7:0] PIC_ROT_SPEC_EOI    = 8'hE0;

    // icw1 view of a command byte
    typedef struct packed {
        logic [2:0] unused_hi;
        logic       init;                                   // marks icw1
        logic       ltim;                                   // level triggered
        logic [1:0] unused_lo;
        logic       ic4;                                    // icw4 follows
    } pic_icw1_t;

    typedef struct packed {
        logic [4:0]            code;                        // eoi kind plus select
        logic [PIC_LINE_W-1:0] line;
    } pic_ocw2_t;

    typedef struct packed {
        logic [2:0] unused_hi;
        logic [1:0] sel;                                    // ocw2 / ocw3 / icw1
        logic       poll;
        logic       rr;                                     // read register enable
        logic       ris;                                    // 1 = isr, 0 = irr
    } pic_ocw3_t;

    // byte written to address 0
    typedef union packed {
        pic_icw1_t  icw1;
        pic_ocw2_t  ocw2;
        pic_ocw3_t  ocw3;
        logic [7:0] raw;
    } pic_cmd_u;

    // per-core configuration from the control registers
    typedef struct packed {
        logic [PIC_LINES-1:0]    mask;                      // imr
        logic                    ltim;
        logic [PIC_OFFSET_W-1:0] offset;
        logic                    read_isr;
    } pic_cfg_t;

endpackage
